//--- compile.f
+incdir+source
source/axil_pkg.sv
source/bitmap_pkg.sv
source/bitmap_write_port.sv
source/bitmap_mem_2rw.sv
source/bitmap_read_port.sv
source/bitmap_top.sv
verification/bitmap_checker.sv
verification/bitmap_tb.sv

//--- Makefile
TOP = bitmap_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --timescale 1ns/1ps -j 0 -f compile.f --top-module $(TOP) -o sim
	out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- verification/bitmap_tb.sv
`timescale 1ns/1ps
`include "bitmap_settings.svh"

module bitmap_tb
  import axil_pkg::*;
  import bitmap_pkg::*;
();

  localparam int rand_ops_lp = 400;
  localparam int txn_lp      = 2 * `BITMAP_ELS + rand_ops_lp + 3; // fill, random mix, collision.
  localparam int limit_lp    = 16 + txn_lp * 40;

  logic         clk, rst_n, stall, done;
  logic         awvalid, awready, wvalid, wready, bvalid, bready;
  logic         arvalid, arready, rvalid, rready;
  bitmap_addr_u awaddr, araddr;
  bitmap_word_t wdata, rdata;
  axil_strb_t   wstrb;
  axil_resp_t   bresp, rresp;
  int           err_cnt, writes, reads;

  bitmap_top dut0 (
    .clk_i (clk), .rst_n_i (rst_n),
    .awvalid_i (awvalid), .awready_o (awready), .awaddr_i (awaddr),
    .wvalid_i (wvalid), .wready_o (wready), .wdata_i (wdata), .wstrb_i (wstrb),
    .bvalid_o (bvalid), .bready_i (bready), .bresp_o (bresp),
    .arvalid_i (arvalid), .arready_o (arready), .araddr_i (araddr),
    .rvalid_o (rvalid), .rready_i (rready), .rdata_o (rdata), .rresp_o (rresp)
  );

  bitmap_checker chk0 (
    .clk_i (clk), .rst_n_i (rst_n), .done_i (done),
    .awvalid_i (awvalid), .awready_i (awready), .wvalid_i (wvalid), .wready_i (wready),
    .awaddr_i (awaddr), .wdata_i (wdata), .wstrb_i (wstrb),
    .bvalid_i (bvalid), .bready_i (bready), .bresp_i (bresp),
    .arvalid_i (arvalid), .arready_i (arready), .araddr_i (araddr),
    .rvalid_i (rvalid), .rready_i (rready), .rdata_i (rdata), .rresp_i (rresp),
    .err_cnt_o (err_cnt)
  );

  function automatic bitmap_addr_u make_addr(logic region, logic op, int idx);
    bitmap_addr_u a;
    a = '0;
    a.bitop.region = region;
    a.bitop.op     = op;
    a.bitop.idx    = bitmap_idx_t'(idx);
    return a;
  endfunction

  task automatic write_word(bitmap_addr_u addr, bitmap_word_t data, axil_strb_t strb);
    @(posedge clk);
    #1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    @(negedge clk);
    while (!awready)
      @(negedge clk);
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    writes++;
  endtask

  task automatic read_word(bitmap_addr_u addr);
    @(posedge clk);
    #1;
    arvalid = 1'b1;
    araddr  = addr;
    @(negedge clk);
    while (!arready)
      @(negedge clk);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    reads++;
  endtask

  task automatic random_write();
    bitmap_addr_u addr;
    addr = make_addr(1'($urandom_range(1)), 1'($urandom_range(1)),
                     $urandom_range(`BITMAP_ELS - 1));
    write_word(addr, $urandom(), axil_strb_t'($urandom()));
  endtask

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // B and R back-pressure, random only while stall is set.
  initial
  begin
    bready = 1'b1;
    rready = 1'b1;
    forever
    begin
      @(posedge clk);
      #1;
      bready = stall ? 1'($urandom_range(1)) : 1'b1;
      rready = stall ? 1'($urandom_range(1)) : 1'b1;
    end
  end

  initial
  begin
    repeat (limit_lp) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", limit_lp);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(26253));
    rst_n   = 1'b0;
    stall   = 1'b0;
    done    = 1'b0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    awaddr  = '0;
    araddr  = '0;
    wdata   = '0;
    wstrb   = '0;
    writes  = 0;
    reads   = 0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < `BITMAP_ELS; i++)
      write_word(make_addr(1'b0, 1'b0, i), $urandom(), '1);
    for (int i = 0; i < `BITMAP_ELS; i++)
      read_word(make_addr(1'($urandom_range(1)), 1'b0, i));
    stall = 1'b1;
    fork
      repeat (rand_ops_lp / 2) random_write();
      repeat (rand_ops_lp / 2) read_word(make_addr(1'($urandom_range(1)), 1'b0,
                                                   $urandom_range(`BITMAP_ELS - 1)));
    join
    stall = 1'b0;
    repeat (4) @(posedge clk);
    // a set and a read of word 5 meet on the same edge.
    fork
      write_word(make_addr(1'b1, 1'b0, 5), 32'h0f0f_0f0f, '1);
      read_word(make_addr(1'b0, 1'b0, 5));
    join
    read_word(make_addr(1'b0, 1'b0, 5));
    repeat (4) @(posedge clk);
    done = 1'b1;
    repeat (2) @(posedge clk);
    $display("errors %0d, writes %0d, reads %0d", err_cnt, writes, reads);
    if (err_cnt == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- verification/bitmap_checker.sv
`timescale 1ns/1ps
`include "bitmap_settings.svh"

module bitmap_checker
  import axil_pkg::*;
  import bitmap_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         done_i,
  input  logic         awvalid_i, awready_i, wvalid_i, wready_i,
  input  bitmap_addr_u awaddr_i,
  input  bitmap_word_t wdata_i,
  input  axil_strb_t   wstrb_i,
  input  logic         bvalid_i, bready_i,
  input  axil_resp_t   bresp_i,
  input  logic         arvalid_i, arready_i,
  input  bitmap_addr_u araddr_i,
  input  logic         rvalid_i, rready_i,
  input  bitmap_word_t rdata_i,
  input  axil_resp_t   rresp_i,
  output int           err_cnt_o
);

  bitmap_word_t ref_mem [`BITMAP_ELS];
  bitmap_word_t exp_q [$];
  bitmap_word_t r_last;
  logic         b_exp, r_exp, r_hold, done_seen;
  logic         w_rdy_exp, ar_rdy_exp;
  int           b_pend;

  // plain writes replace the strobed bytes, bit-ops set or clear the 1 bits of data.
  function automatic bitmap_word_t ref_write(bitmap_word_t old, bitmap_addr_u addr,
                                             bitmap_word_t data, axil_strb_t strb);
    bitmap_word_t res;
    res = old;
    if (addr.plain.region == 1'b0)
    begin
      for (int b = 0; b < $bits(axil_strb_t); b++)
      begin
        if (strb[b])
          res[8*b +: 8] = data[8*b +: 8];
      end
    end
    else if (addr.bitop.op == 1'b0)
      res = old | data;
    else
      res = old & ~data;
    return res;
  endfunction

  task automatic report_mismatch(string msg);
    $display("ERR %0t: %s", $time, msg);
    err_cnt_o++;
  endtask

  // inputs settle 1 ns after the rising edge, so the falling edge sees what the next edge takes.
  always @(negedge clk_i)
  begin
    if (!rst_n_i)
    begin
      b_exp     = 1'b0;
      r_exp     = 1'b0;
      r_hold    = 1'b0;
      done_seen = 1'b0;
      b_pend    = 0;
      err_cnt_o = 0;
    end
    else
    begin
      if (bvalid_i !== b_exp)
        report_mismatch($sformatf("bvalid_o is %b, expected %b", bvalid_i, b_exp));
      if (rvalid_i !== r_exp)
        report_mismatch($sformatf("rvalid_o is %b, expected %b", rvalid_i, r_exp));
      // a slave is ready only while its response channel is empty.
      w_rdy_exp  = awvalid_i && wvalid_i && !b_exp;
      ar_rdy_exp = arvalid_i && !r_exp;
      if (awready_i !== w_rdy_exp)
        report_mismatch($sformatf("awready_o is %b, expected %b", awready_i, w_rdy_exp));
      if (wready_i !== w_rdy_exp)
        report_mismatch($sformatf("wready_o is %b, expected %b", wready_i, w_rdy_exp));
      if (arready_i !== ar_rdy_exp)
        report_mismatch($sformatf("arready_o is %b, expected %b", arready_i, ar_rdy_exp));
      if (rvalid_i && r_hold && rdata_i !== r_last)
        report_mismatch($sformatf("rdata_o moved from %h to %h under stall", r_last, rdata_i));
      if (bvalid_i && bready_i)
      begin
        if (b_pend == 0)
          report_mismatch("B beat without a write");
        else
          b_pend--;
        if (bresp_i !== OKAY)
          report_mismatch($sformatf("bresp_o is %b", bresp_i));
      end
      if (rvalid_i && rready_i)
      begin
        if (exp_q.size() == 0)
          report_mismatch("R beat without a read");
        else if (rdata_i !== exp_q[0])
          report_mismatch($sformatf("rdata_o is %h, expected %h", rdata_i, exp_q[0]));
        if (exp_q.size() != 0)
          void'(exp_q.pop_front());
        if (rresp_i !== OKAY)
          report_mismatch($sformatf("rresp_o is %b", rresp_i));
      end
      // the read is sampled before the write so a collision sees the old word.
      if (arvalid_i && arready_i)
        exp_q.push_back(ref_mem[araddr_i.plain.idx]);
      if (awvalid_i && awready_i && wvalid_i && wready_i)
      begin
        ref_mem[awaddr_i.plain.idx] = ref_write(ref_mem[awaddr_i.plain.idx], awaddr_i,
                                                wdata_i, wstrb_i);
        b_pend++;
      end
      b_exp  = (awvalid_i && awready_i && wvalid_i && wready_i) || (bvalid_i && !bready_i);
      r_exp  = (arvalid_i && arready_i) || (rvalid_i && !rready_i);
      r_hold = rvalid_i && !rready_i;
      r_last = rdata_i;
      if (done_i && !done_seen)
      begin
        done_seen = 1'b1;
        if (b_pend != 0 || exp_q.size() != 0)
        begin
          $display("missing responses: %0d write and %0d read responses never arrived",
                   b_pend, exp_q.size());
          err_cnt_o++;
        end
      end
    end
  end

endmodule

//--- source/bitmap_top.sv
`timescale 1ns/1ps
`include "bitmap_settings.svh"

module bitmap_top
  import axil_pkg::*;
  import bitmap_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,

  input  logic         awvalid_i,
  output logic         awready_o,
  input  bitmap_addr_u awaddr_i,

  input  logic         wvalid_i,
  output logic         wready_o,
  input  bitmap_word_t wdata_i,
  input  axil_strb_t   wstrb_i,

  output logic         bvalid_o,
  input  logic         bready_i,
  output axil_resp_t   bresp_o,

  input  logic         arvalid_i,
  output logic         arready_o,
  input  bitmap_addr_u araddr_i,

  output logic         rvalid_o,
  input  logic         rready_i,
  output bitmap_word_t rdata_o,
  output axil_resp_t   rresp_o
);

  logic         a_v;
  bitmap_idx_t  a_addr;
  bitmap_word_t a_data;
  bitmap_word_t a_mask;

  logic         b_v;
  bitmap_idx_t  b_addr;
  bitmap_word_t b_data;

  bitmap_write_port write_port0 (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .awvalid_i  (awvalid_i),
    .awready_o  (awready_o),
    .awaddr_i   (awaddr_i),
    .wvalid_i   (wvalid_i),
    .wready_o   (wready_o),
    .wdata_i    (wdata_i),
    .wstrb_i    (wstrb_i),
    .bvalid_o   (bvalid_o),
    .bready_i   (bready_i),
    .bresp_o    (bresp_o),
    .mem_v_o    (a_v),
    .mem_addr_o (a_addr),
    .mem_data_o (a_data),
    .mem_mask_o (a_mask)
  );

  // port A only writes and port B only reads.
  bitmap_mem_2rw #(
    .width_p (`BITMAP_WIDTH),
    .els_p   (`BITMAP_ELS)
  ) mem0 (
    .clk_i      (clk_i),
    .a_v_i      (a_v),
    .a_w_i      (1'b1),
    .a_addr_i   (a_addr),
    .a_data_i   (a_data),
    .a_w_mask_i (a_mask),
    .b_v_i      (b_v),
    .b_w_i      (1'b0),
    .b_addr_i   (b_addr),
    .b_data_i   ('0),
    .b_w_mask_i ('0),
    .a_data_o   (),
    .b_data_o   (b_data)
  );

  bitmap_read_port read_port0 (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .arvalid_i  (arvalid_i),
    .arready_o  (arready_o),
    .araddr_i   (araddr_i),
    .rvalid_o   (rvalid_o),
    .rready_i   (rready_i),
    .rdata_o    (rdata_o),
    .rresp_o    (rresp_o),
    .mem_v_o    (b_v),
    .mem_addr_o (b_addr),
    .mem_data_i (b_data)
  );

endmodule

//--- source/bitmap_read_port.sv
`timescale 1ns/1ps

module bitmap_read_port
  import axil_pkg::*;
  import bitmap_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,

  input  logic         arvalid_i,
  output logic         arready_o,
  input  bitmap_addr_u araddr_i,

  output logic         rvalid_o,
  input  logic         rready_i,
  output bitmap_word_t rdata_o,
  output axil_resp_t   rresp_o,

  output logic         mem_v_o,
  output bitmap_idx_t  mem_addr_o,
  input  bitmap_word_t mem_data_i
);

  logic         rvalid_r;
  logic         fresh_r;  // high in the first cycle of R, when the RAM word arrives.
  bitmap_word_t rdata_r;

  assign arready_o  = arvalid_i & ~rvalid_r;
  assign mem_v_o    = arready_o;
  assign mem_addr_o = araddr_i.plain.idx; // both regions read the same word.

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      rvalid_r <= 1'b0;
      fresh_r  <= 1'b0;
    end
    else
    begin
      fresh_r <= arready_o;
      if (arready_o)
      begin
        rvalid_r <= 1'b1;
      end
      else if (rready_i)
      begin
        rvalid_r <= 1'b0;
      end
    end
  end

  // keep the word so R stays stable while the master stalls.
  always_ff @(posedge clk_i)
  begin
    if (fresh_r)
    begin
      rdata_r <= mem_data_i;
    end
  end

  assign rvalid_o = rvalid_r;
  assign rdata_o  = fresh_r ? mem_data_i : rdata_r;
  assign rresp_o  = OKAY;

endmodule

//--- source/bitmap_mem_2rw.sv
`timescale 1ns/1ps

module bitmap_mem_2rw #(
  parameter int width_p       = 32,
  parameter int els_p         = 64,
  parameter int addr_width_lp = $clog2(els_p)
)
(
  input  logic                     clk_i,

  input  logic                     a_v_i,
  input  logic                     a_w_i,
  input  logic [addr_width_lp-1:0] a_addr_i,
  input  logic [width_p-1:0]       a_data_i,
  input  logic [width_p-1:0]       a_w_mask_i,

  input  logic                     b_v_i,
  input  logic                     b_w_i,
  input  logic [addr_width_lp-1:0] b_addr_i,
  input  logic [width_p-1:0]       b_data_i,
  input  logic [width_p-1:0]       b_w_mask_i,

  output logic [width_p-1:0]       a_data_o,
  output logic [width_p-1:0]       b_data_o
);

  logic [width_p-1:0] mem_r [els_p];

  // all accesses share one edge, so a read sees the word as it was before any write.
  always_ff @(posedge clk_i)
  begin
    if (a_v_i & ~a_w_i)
    begin
      a_data_o <= mem_r[a_addr_i];
    end
    if (b_v_i & ~b_w_i)
    begin
      b_data_o <= mem_r[b_addr_i];
    end
    if (a_v_i & a_w_i)
    begin
      mem_r[a_addr_i] <= (mem_r[a_addr_i] & ~a_w_mask_i) | (a_data_i & a_w_mask_i);
    end
    if (b_v_i & b_w_i)
    begin
      mem_r[b_addr_i] <= (mem_r[b_addr_i] & ~b_w_mask_i) | (b_data_i & b_w_mask_i);
    end
  end

endmodule

//--- source/bitmap_write_port.sv
`timescale 1ns/1ps

module bitmap_write_port
  import axil_pkg::*;
  import bitmap_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,

  input  logic         awvalid_i,
  output logic         awready_o,
  input  bitmap_addr_u awaddr_i,

  input  logic         wvalid_i,
  output logic         wready_o,
  input  bitmap_word_t wdata_i,
  input  axil_strb_t   wstrb_i,

  output logic         bvalid_o,
  input  logic         bready_i,
  output axil_resp_t   bresp_o,

  output logic         mem_v_o,
  output bitmap_idx_t  mem_addr_o,
  output bitmap_word_t mem_data_o,
  output bitmap_word_t mem_mask_o
);

  logic bvalid_r;
  logic accept;

  // address and data are only taken as a pair.
  assign accept = awvalid_i & wvalid_i & ~bvalid_r;

  assign awready_o = accept;
  assign wready_o  = accept;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      bvalid_r <= 1'b0;
    end
    else if (accept)
    begin
      bvalid_r <= 1'b1; // response is due the cycle after the handshake.
    end
    else if (bready_i)
    begin
      bvalid_r <= 1'b0;
    end
  end

  assign bvalid_o = bvalid_r;
  assign bresp_o  = OKAY;

  // the RAM write happens on the same edge as the handshake.
  assign mem_v_o    = accept;
  assign mem_addr_o = awaddr_i.plain.idx;

  always_comb
  begin
    if (!awaddr_i.plain.region)
    begin
      mem_data_o = wdata_i;
      for (int i = 0; i < $bits(axil_strb_t); i++)
      begin
        mem_mask_o[8*i +: 8] = {8{wstrb_i[i]}}; // each strobe covers one byte.
      end
    end
    else
    begin
      // in a bit-op, WDATA says which bits to touch.
      mem_mask_o = wdata_i;
      if (awaddr_i.bitop.op)
      begin
        mem_data_o = '0;
      end
      else
      begin
        mem_data_o = '1;
      end
    end
  end

endmodule

//--- source/bitmap_pkg.sv
`include "bitmap_settings.svh"

package bitmap_pkg;

  localparam int bitmap_idx_w_lp   = $clog2(`BITMAP_ELS);
  localparam int bitmap_off_w_lp   = $clog2(`BITMAP_WIDTH/8);
  localparam int bitmap_spare_w_lp = `BITMAP_AXI_AW - 1 - bitmap_idx_w_lp - bitmap_off_w_lp;

  typedef logic [`BITMAP_WIDTH-1:0]  bitmap_word_t;
  typedef logic [bitmap_idx_w_lp-1:0] bitmap_idx_t;

  // region 0 holds plain word writes.
  typedef struct packed
  {
    logic                         region;
    logic [bitmap_spare_w_lp-1:0] spare;
    bitmap_idx_t                  idx;
    logic [bitmap_off_w_lp-1:0]   off;
  } bitmap_plain_addr_s;

  // region 1 holds bit-op writes, op 0 sets and op 1 clears.
  typedef struct packed
  {
    logic                       region;
    logic                       op;
    bitmap_idx_t                idx;
    logic [bitmap_off_w_lp-1:0] off;
  } bitmap_bitop_addr_s;

  typedef union packed
  {
    bitmap_plain_addr_s plain;
    bitmap_bitop_addr_s bitop;
  } bitmap_addr_u;

endpackage

//--- source/axil_pkg.sv
`include "bitmap_settings.svh"

package axil_pkg;

  // AXI4-Lite response codes.
  typedef enum logic [1:0]
  {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_t;

  // one strobe bit per data byte.
  typedef logic [`BITMAP_WIDTH/8-1:0] axil_strb_t;

endpackage

//--- source/bitmap_settings.svh
`ifndef BITMAP_SETTINGS_SVH
`define BITMAP_SETTINGS_SVH

// width of one table word in bits.
`define BITMAP_WIDTH 32

// number of words in the table.
`define BITMAP_ELS 64

// AXI4-Lite address width; bit 9 picks the region and bit 8 the bit-op.
`define BITMAP_AXI_AW 10

`endif
